// File: build.f
+incdir+rtl
rtl/aux_audio_pkg.sv
rtl/aux_audio_stream.sv
rtl/aux_sample_pacer.sv
rtl/aux_audio_mixer.sv
rtl/sigma_delta_dac.sv
rtl/aux_audio_top.sv
test/aux_audio_assert.sv
test/aux_audio_tb.sv

// File: rtl/aux_audio_defines.svh
`ifndef AUX_AUDIO_DEFINES_SVH
`define AUX_AUDIO_DEFINES_SVH

// Sample pacing, 114.75 MHz / 2571 gives roughly 44.6 kHz
`define AUD_TICK_PERIOD 2571

// Cycles between the left pop and the right pop
`define AUD_PAIR_GAP 4

// Words per RAM burst
`define AUD_BURST_LEN 4

// Prefetch FIFO size in words, power of two
`define AUD_FIFO_DEPTH 16

// Upper bits of the word address, audio buffer sits at 0x6f0000 in SDRAM
`define AUD_RAM_PREFIX 7'b1101111

`endif

// File: rtl/aux_audio_mixer.sv
`default_nettype none

module aux_audio_mixer (
  input  wire                                clk_114,
  input  wire                                rst,
  input  wire aux_audio_pkg::stereo_sample_t amiga,
  input  wire aux_audio_pkg::stereo_sample_t aux,
  input  wire aux_audio_pkg::stereo_sample_t cdda,
  output aux_audio_pkg::stereo_sample_t      mix
);

  // Two guard bits cover the sum of three full-scale inputs
  localparam int SW = 18;

  logic [SW-1:0] sum_l;
  logic [SW-1:0] sum_r;

  function automatic logic [SW-1:0] widen(input logic [15:0] s);
    return {{(SW - 16){s[15]}}, s};
  endfunction

  // In range while the guard bits match the sign of bit 15
  function automatic logic [15:0] clamp(input logic [SW-1:0] s);
    if (s[SW-1:15] == '0 || s[SW-1:15] == '1)
      return s[15:0];
    else if (s[SW-1])
      return 16'h8000;  // Negative full scale
    else
      return 16'h7fff;
  endfunction

  assign sum_l = widen(amiga.left) + widen(aux.left) + widen(cdda.left);
  assign sum_r = widen(amiga.right) + widen(aux.right) + widen(cdda.right);

  always_ff @(posedge clk_114) begin
    if (rst) begin
      mix <= '0;
    end else begin
      mix.left  <= clamp(sum_l);
      mix.right <= clamp(sum_r);
    end
  end

endmodule

`default_nettype wire

// File: rtl/aux_audio_pkg.sv
`default_nettype none

package aux_audio_pkg;

  // Burst request towards the RAM arbiter
  typedef struct packed {
    logic        req;
    logic [22:0] addr;  // Word address
  } aud_ram_req_t;

  // Arbiter answer, one ack then one fill strobe per word
  typedef struct packed {
    logic        ack;
    logic        fill;
    logic [15:0] data;
  } aud_ram_rsp_t;

  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } stereo_sample_t;

  typedef enum logic [1:0] {
    idle,
    request,
    filling
  } stream_state_t;

  typedef enum logic {
    slot_left,
    slot_right
  } sample_slot_t;

endpackage

`default_nettype wire

// File: rtl/aux_audio_stream.sv
`default_nettype none

`include "aux_audio_defines.svh"

module aux_audio_stream (
  input  wire                          clk_114,
  input  wire                          rst,
  input  wire                          aux_enable,
  output aux_audio_pkg::aud_ram_req_t  ram_req,
  input  wire aux_audio_pkg::aud_ram_rsp_t ram_rsp,
  input  wire                          pop,
  output logic [15:0]                  head,
  output logic                         empty,
  output logic                         buf_half
);

  import aux_audio_pkg::*;

  localparam int AW = $clog2(`AUD_FIFO_DEPTH);
  localparam int FW = $clog2(`AUD_BURST_LEN + 1);

  stream_state_t state;
  logic [15:0]   offset;      // Word offset of the next request
  logic [FW-1:0] fills_left;  // Words still owed by the RAM
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   level;
  logic [15:0]   mem [`AUD_FIFO_DEPTH];
  logic          push;
  logic          do_pop;
  logic          room;

  //////////////////////////////////////////////////////////////////////////
  // Burst fetcher
  //////////////////////////////////////////////////////////////////////////

  // Only space not already promised to a burst counts
  assign room = (int'(level) + int'(fills_left) + `AUD_BURST_LEN) <= `AUD_FIFO_DEPTH;

  assign push = (state == filling) && ram_rsp.fill;

  always_ff @(posedge clk_114) begin
    if (rst || !aux_enable) begin
      state      <= idle;
      offset     <= '0;
      fills_left <= '0;
    end else begin
      case (state)
        idle: begin
          if (room)
            state <= request;
        end
        request: begin
          if (ram_rsp.ack) begin  // Address is consumed here
            state      <= filling;
            fills_left <= FW'(`AUD_BURST_LEN);
            offset     <= offset + 16'(`AUD_BURST_LEN);  // Wraps at 64K words
          end
        end
        filling: begin
          if (push) begin
            fills_left <= fills_left - 1'b1;
            if (fills_left == FW'(1))
              state <= idle;  // Last word of the burst
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign ram_req = '{req: (state == request), addr: {`AUD_RAM_PREFIX, offset}};

  assign buf_half = offset[15];  // Tells the CPU which half is being played

  //////////////////////////////////////////////////////////////////////////
  // Prefetch FIFO, show-ahead
  //////////////////////////////////////////////////////////////////////////

  assign do_pop = pop && (level != '0);

  always_ff @(posedge clk_114) begin
    if (rst || !aux_enable) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk_114) begin
    if (push)
      mem[wr_ptr] <= ram_rsp.data;
  end

  assign head  = mem[rd_ptr];
  assign empty = (level == '0);

endmodule

`default_nettype wire

// File: rtl/aux_audio_top.sv
`default_nettype none

module aux_audio_top (
  input  wire                                clk_114,
  input  wire                                rst,
  input  wire                                aux_enable,   // Level from the CPU
  // RAM arbiter
  output aux_audio_pkg::aud_ram_req_t        ram_req,
  input  wire aux_audio_pkg::aud_ram_rsp_t   ram_rsp,
  // Other audio sources, held levels
  input  wire aux_audio_pkg::stereo_sample_t amiga_audio,
  input  wire aux_audio_pkg::stereo_sample_t cdda_audio,
  // Mixed output
  output aux_audio_pkg::stereo_sample_t      pcm,
  output logic                               audio_l,
  output logic                               audio_r,
  output logic                               buf_half
);

  import aux_audio_pkg::*;

  logic [15:0]    fifo_head;
  logic           fifo_empty;
  logic           fifo_pop;
  stereo_sample_t aux_sample;  // Byte-swapped pair from the buffer

  //////////////////////////////////////////////////////////////////////////
  // Buffer fetch and pacing
  //////////////////////////////////////////////////////////////////////////

  aux_audio_stream u_stream (
    .clk_114    (clk_114),
    .rst        (rst),
    .aux_enable (aux_enable),
    .ram_req    (ram_req),
    .ram_rsp    (ram_rsp),
    .pop        (fifo_pop),
    .head       (fifo_head),
    .empty      (fifo_empty),
    .buf_half   (buf_half)
  );

  aux_sample_pacer u_pacer (
    .clk_114 (clk_114),
    .rst     (rst),
    .head    (fifo_head),
    .empty   (fifo_empty),
    .pop     (fifo_pop),
    .aux     (aux_sample)
  );

  //////////////////////////////////////////////////////////////////////////
  // Mixing and DAC
  //////////////////////////////////////////////////////////////////////////

  aux_audio_mixer u_mixer (
    .clk_114 (clk_114),
    .rst     (rst),
    .amiga   (amiga_audio),
    .aux     (aux_sample),
    .cdda    (cdda_audio),
    .mix     (pcm)             // Also the digital PCM output
  );

  sigma_delta_dac u_dac (
    .clk_114 (clk_114),
    .rst     (rst),
    .pcm     (pcm),
    .audio_l (audio_l),
    .audio_r (audio_r)
  );

endmodule

`default_nettype wire

// File: rtl/aux_sample_pacer.sv
`default_nettype none

`include "aux_audio_defines.svh"

module aux_sample_pacer (
  input  wire                           clk_114,
  input  wire                           rst,
  input  wire logic [15:0]              head,
  input  wire                           empty,
  output logic                          pop,
  output aux_audio_pkg::stereo_sample_t aux
);

  import aux_audio_pkg::*;

  localparam int TW = $clog2(`AUD_TICK_PERIOD);
  localparam int GW = $clog2(`AUD_PAIR_GAP + 1);

  logic [TW-1:0] tick_cnt;
  logic          tick;
  sample_slot_t  slot;     // Which channel gets the next pop
  logic [GW-1:0] gap_cnt;
  logic          pop_left;
  logic          pop_right;
  logic [15:0]   swapped;

  assign tick      = (tick_cnt == TW'(`AUD_TICK_PERIOD - 1));
  assign pop_left  = tick;
  assign pop_right = (slot == slot_right) && (gap_cnt == '0);
  assign pop       = pop_left || pop_right;

  // Buffer holds big-endian words
  assign swapped = empty ? 16'h0000 : {head[7:0], head[15:8]};

  always_ff @(posedge clk_114) begin
    if (rst || tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  always_ff @(posedge clk_114) begin
    if (rst) begin
      slot    <= slot_left;
      gap_cnt <= '0;
    end else if (slot == slot_left) begin
      if (pop_left) begin
        slot    <= slot_right;
        gap_cnt <= GW'(`AUD_PAIR_GAP - 1);
      end
    end else if (pop_right) begin
      slot <= slot_left;
    end else begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_114) begin
    if (rst) begin
      aux <= '0;
    end else begin
      if (pop_left)
        aux.left <= swapped;
      if (pop_right)
        aux.right <= swapped;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sigma_delta_dac.sv
`default_nettype none

module sigma_delta_dac (
  input  wire                                clk_114,
  input  wire                                rst,
  input  wire aux_audio_pkg::stereo_sample_t pcm,
  output logic                               audio_l,
  output logic                               audio_r
);

  logic [1:0][15:0] level;  // Offset binary, index 0 is left
  logic [1:0][15:0] acc;
  logic [1:0][16:0] sum;
  logic [1:0]       bits;

  // Flip the sign so that silence sits at mid scale
  assign level[0] = {~pcm.left[15], pcm.left[14:0]};
  assign level[1] = {~pcm.right[15], pcm.right[14:0]};

  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      sum[ch] = {1'b0, acc[ch]} + {1'b0, level[ch]};
    end
  end

  // Carry density equals level / 65536
  always_ff @(posedge clk_114) begin
    if (rst) begin
      acc  <= '0;
      bits <= '0;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        acc[ch]  <= sum[ch][15:0];
        bits[ch] <= sum[ch][16];
      end
    end
  end

  assign audio_l = bits[0];
  assign audio_r = bits[1];

endmodule

`default_nettype wire

// File: test/aux_audio_assert.sv
`default_nettype none

`include "aux_audio_defines.svh"

module aux_audio_assert (
  input wire                               clk_114,
  input wire                               rst,
  input wire                               aux_enable,
  input wire aux_audio_pkg::aud_ram_req_t  ram_req,
  input wire aux_audio_pkg::aud_ram_rsp_t  ram_rsp
);

  import aux_audio_pkg::*;

  int fill_count;  // Fills seen since the last ack

  always @(posedge clk_114) begin
    if (rst || ram_rsp.ack)
      fill_count <= 0;
    else if (ram_rsp.fill)
      fill_count <= fill_count + 1;
  end

  req_held: assert property (@(posedge clk_114) disable iff (rst || !aux_enable)
    ram_req.req && !ram_rsp.ack |=> ram_req.req && $stable(ram_req.addr))
    else $error("req dropped or address moved before ack");

  ack_with_req: assert property (@(posedge clk_114) disable iff (rst || !aux_enable)
    ram_rsp.ack |-> ram_req.req)
    else $error("ack seen without a pending request");

  // One burst never brings more than its length
  fill_limit: assert property (@(posedge clk_114) disable iff (rst)
    ram_rsp.fill |-> fill_count < `AUD_BURST_LEN)
    else $error("more fills than the burst length after one ack");

endmodule

bind aux_audio_stream aux_audio_assert u_assert (
  .clk_114    (clk_114),
  .rst        (rst),
  .aux_enable (aux_enable),
  .ram_req    (ram_req),
  .ram_rsp    (ram_rsp)
);

`default_nettype wire

// File: test/aux_audio_tb.sv
`default_nettype none

`include "aux_audio_defines.svh"

module aux_audio_tb;

  import aux_audio_pkg::*;

  logic           clk_114;
  logic           rst;
  logic           aux_enable;
  aud_ram_req_t   ram_req;
  aud_ram_rsp_t   ram_rsp;
  stereo_sample_t amiga_audio;
  stereo_sample_t cdda_audio;
  stereo_sample_t pcm;
  logic           audio_l;
  logic           audio_r;
  logic           buf_half;
  logic [22:0]    req_log[$];  // Addresses acked by the RAM model

  aux_audio_top uut (
    .clk_114     (clk_114),
    .rst         (rst),
    .aux_enable  (aux_enable),
    .ram_req     (ram_req),
    .ram_rsp     (ram_rsp),
    .amiga_audio (amiga_audio),
    .cdda_audio  (cdda_audio),
    .pcm         (pcm),
    .audio_l     (audio_l),
    .audio_r     (audio_r),
    .buf_half    (buf_half)
  );

  initial begin
    clk_114 = 1'b0;
    forever #4 clk_114 = ~clk_114;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, msg, actual, expected);
      abort_run("Value mismatch");
    end
  endtask

  function automatic logic [15:0] byte_swap(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  function automatic logic [15:0] saturate(input int a, input int b);
    int s;
    s = a + b;
    if (s > 32767)
      return 16'h7fff;
    else if (s < -32768)
      return 16'h8000;
    return 16'(s);
  endfunction

  // RAM model, random ack delay and random gaps between fills
  task automatic ram_responder();
    logic [22:0] addr;
    int          i;
    forever begin
      @(negedge clk_114);
      if (ram_req.req) begin
        addr = ram_req.addr;
        repeat ($urandom_range(1, 5)) @(negedge clk_114);
        if (ram_req.req && ram_req.addr == addr) begin
          req_log.push_back(addr);
          ram_rsp.ack = 1'b1;
          @(negedge clk_114);
          ram_rsp.ack = 1'b0;
          for (i = 0; i < `AUD_BURST_LEN; i++) begin
            repeat ($urandom_range(0, 3)) @(negedge clk_114);
            ram_rsp.fill = 1'b1;
            ram_rsp.data = (addr[15:0] + 16'(i)) ^ 16'h5a3c;
            @(negedge clk_114);
            ram_rsp.fill = 1'b0;
          end
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state_zero();
    check_value(ram_req.req, 0, "req after reset");
    check_value({audio_l, audio_r}, 0, "DAC bits after reset");
    check_value(buf_half, 0, "buf_half after reset");
    check_value(pcm, 0, "pcm after reset");
  endtask

  task automatic mixer_saturation();
    int a_l[4] = '{30000, -30000, 1234, 0};
    int c_l[4] = '{5000, -5000, -34, -32768};
    int a_r[4] = '{-20000, 32767, 100, -1};
    int c_r[4] = '{-20000, 32767, -300, 1};
    int k;
    for (k = 0; k < 4; k++) begin
      amiga_audio = '{left: 16'(a_l[k]), right: 16'(a_r[k])};
      cdda_audio  = '{left: 16'(c_l[k]), right: 16'(c_r[k])};
      @(negedge clk_114);
      check_value(pcm, {saturate(a_l[k], c_l[k]), saturate(a_r[k], c_r[k])}, "mixer sum");
    end
  endtask

  task automatic dac_ones_density();
    logic [15:0] v_l;
    logic [15:0] v_r;
    int          ones_l;
    int          ones_r;
    v_l = 16'h1234;
    v_r = 16'hd000;
    amiga_audio = '{left: v_l, right: v_r};
    cdda_audio  = '0;
    repeat (4) @(negedge clk_114);
    ones_l = 0;
    ones_r = 0;
    repeat (65536) begin
      @(negedge clk_114);
      ones_l += audio_l;
      ones_r += audio_r;
    end
    // Signed value moved up by half scale
    check_value(ones_l, $signed(v_l) + 32768, "ones on audio_l");
    check_value(ones_r, $signed(v_r) + 32768, "ones on audio_r");
  endtask

  task automatic buffer_playback();
    stereo_sample_t prev;
    logic [15:0]    exp_l;
    logic [15:0]    exp_r;
    int             n;
    int             t;
    amiga_audio = '0;
    cdda_audio  = '0;
    // Start right after a tick so the first pair comes from a full FIFO
    t = 0;
    while (!uut.u_pacer.tick && t < 2 * `AUD_TICK_PERIOD) begin
      @(negedge clk_114);
      t++;
    end
    if (t >= 2 * `AUD_TICK_PERIOD)
      abort_run("Timeout waiting for the pacer tick");
    repeat (10) @(negedge clk_114);
    check_value(pcm, 0, "pcm before playback");
    aux_enable = 1'b1;
    exp_l = 16'h0000;
    exp_r = 16'h0000;
    prev  = pcm;
    for (n = 0; n < 12; n++) begin
      t = 0;
      while (pcm == prev && t < 2 * `AUD_TICK_PERIOD) begin
        @(negedge clk_114);
        t++;
      end
      if (t >= 2 * `AUD_TICK_PERIOD)
        abort_run("Timeout waiting for a pcm change");
      if (n % 2 == 0)
        exp_l = byte_swap(16'(n) ^ 16'h5a3c);  // Even words go left
      else
        exp_r = byte_swap(16'(n) ^ 16'h5a3c);
      check_value(pcm, {exp_l, exp_r}, "played sample pair");
      prev = pcm;
    end
  endtask

  task automatic request_address_order();
    int i;
    check_value(req_log.size() >= 3, 1, "number of bursts");
    for (i = 0; i < req_log.size(); i++)
      check_value(req_log[i], {`AUD_RAM_PREFIX, 16'(i * `AUD_BURST_LEN)}, "request address");
  endtask

  task automatic disable_clears_stream();
    stereo_sample_t expect_mix;
    int             t;
    aux_enable  = 1'b0;
    amiga_audio = '{left: 16'sd1000, right: -16'sd2000};
    cdda_audio  = '{left: 16'sd300, right: 16'sd45};
    expect_mix  = '{left: saturate(1000, 300), right: saturate(-2000, 45)};
    @(negedge clk_114);
    check_value(ram_req.req, 0, "req after disable");
    check_value(uut.u_stream.empty, 1, "FIFO empty after disable");
    check_value(buf_half, 0, "buf_half after disable");
    // Next tick pops the empty FIFO into both channels
    t = 0;
    while (!uut.u_pacer.tick && t < 2 * `AUD_TICK_PERIOD) begin
      @(negedge clk_114);
      t++;
    end
    if (t >= 2 * `AUD_TICK_PERIOD)
      abort_run("Timeout waiting for the pacer tick after disable");
    repeat (`AUD_PAIR_GAP + 2) @(negedge clk_114);  // Right capture plus mixer cycle
    check_value(pcm, expect_mix, "pcm without buffer");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h27dd_f814));
    rst         = 1'b1;
    aux_enable  = 1'b0;
    ram_rsp     = '0;
    amiga_audio = '0;
    cdda_audio  = '0;
    fork
      ram_responder();
    join_none
    repeat (10) @(posedge clk_114);
    @(negedge clk_114);
    rst = 1'b0;
    @(negedge clk_114);
    reset_state_zero();
    mixer_saturation();
    dac_ones_density();
    buffer_playback();
    request_address_order();
    disable_clears_stream();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
